// ==== verilog/wb_pkg.sv ====
/* Wishbone bus widths and the request and response bundles shared by
   every manager and target */
`default_nettype none

package wb_pkg;

    localparam int WB_AW = 32;
    localparam int WB_DW = 32;

    // Manager to target
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [3:0]       sel;          // Byte lanes
        logic [WB_AW-1:0] adr;
        logic [WB_DW-1:0] dat;
    } wb_req_t;

    // Target to manager
    typedef struct packed {
        logic             ack;
        logic [WB_DW-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/soc_map_pkg.sv ====
/* Address map of the user area, copy-engine register offsets and states,
   and the pad/LA source-select codes */
`default_nettype none

package soc_map_pkg;

    // Target regions from adr[13:12]
    typedef enum logic [1:0] {
        REG_SRAM = 2'd0,
        REG_GPIO = 2'd1,
        REG_LA   = 2'd2,
        REG_TEAM = 2'd3
    } region_e;

    localparam logic [17:0] MAP_BASE_HI = 18'h0_C000;  // adr[31:14] of 0x3000_0000

    // Copy-engine word offsets inside REG_TEAM
    localparam logic [1:0] COPY_SRC  = 2'd0;
    localparam logic [1:0] COPY_DST  = 2'd1;
    localparam logic [1:0] COPY_LEN  = 2'd2;
    localparam logic [1:0] COPY_CTRL = 2'd3;

    typedef enum logic [1:0] {
        CP_IDLE  = 2'd0,
        CP_READ  = 2'd1,
        CP_WRITE = 2'd2
    } copy_state_e;

    localparam logic [31:0] SRC_NONE  = 32'd0;  // Default pad/LA values
    localparam logic [31:0] SRC_TEAM5 = 32'd1;

endpackage

`default_nettype wire

// ==== verilog/wb_arbiter.sv ====
/* Round-robin arbiter for the host and copy-engine managers, grant held
   for a whole bus cycle */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  logic            wb_clk_i,
    input  logic            reset_i,
    input  wb_pkg::wb_req_t host_req_i,
    input  wb_pkg::wb_req_t cpu_req_i,
    output wb_pkg::wb_rsp_t host_rsp_o,
    output wb_pkg::wb_rsp_t cpu_rsp_o,
    output wb_pkg::wb_req_t bus_req_o,
    input  wb_pkg::wb_rsp_t bus_rsp_i
);

    logic [1:0] grant_q;        // One-hot {cpu, host}, zero when idle
    logic       last_cpu_q;     // Manager served most recently
    logic       pick_cpu;
    logic       owner_done;

    // Tie goes to whoever was not served last
    assign pick_cpu = cpu_req_i.cyc && (!host_req_i.cyc || !last_cpu_q);

    assign owner_done = (grant_q[0] && !host_req_i.cyc) ||
                        (grant_q[1] && !cpu_req_i.cyc);

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            grant_q    <= 2'b00;
            last_cpu_q <= 1'b0;
        end else if (grant_q != 2'b00) begin
            if (owner_done) begin
                grant_q <= 2'b00;   // Release after cyc drops
            end
        end else if (host_req_i.cyc || cpu_req_i.cyc) begin
            grant_q    <= pick_cpu ? 2'b10 : 2'b01;
            last_cpu_q <= pick_cpu;
        end
    end

    // Only the owner reaches the bus and sees its response
    always_comb begin
        bus_req_o  = '0;
        host_rsp_o = '0;
        cpu_rsp_o  = '0;
        if (grant_q[0]) begin
            bus_req_o  = host_req_i;
            host_rsp_o = bus_rsp_i;
        end else if (grant_q[1]) begin
            bus_req_o = cpu_req_i;
            cpu_rsp_o = bus_rsp_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/wb_decoder.sv ====
/* Region decoder: routes the bus request to one target, muxes its
   response, and answers unmapped accesses with zero */
`timescale 1ns/1ps
`default_nettype none

module wb_decoder (
    input  logic            wb_clk_i,
    input  logic            reset_i,
    input  wb_pkg::wb_req_t bus_req_i,
    output wb_pkg::wb_rsp_t bus_rsp_o,
    output wb_pkg::wb_req_t sram_req_o,
    output wb_pkg::wb_req_t gpio_req_o,
    output wb_pkg::wb_req_t la_req_o,
    output wb_pkg::wb_req_t team_req_o,
    input  wb_pkg::wb_rsp_t sram_rsp_i,
    input  wb_pkg::wb_rsp_t gpio_rsp_i,
    input  wb_pkg::wb_rsp_t la_rsp_i,
    input  wb_pkg::wb_rsp_t team_rsp_i
);
    import wb_pkg::*;
    import soc_map_pkg::*;

    region_e region;
    logic    mapped;
    logic    unm_ack_q;

    // Copy of the request with cyc/stb kept only for the hit target
    function automatic wb_req_t route(input wb_req_t r, input logic hit);
        wb_req_t t;
        t     = r;
        t.cyc = r.cyc & hit;
        t.stb = r.stb & hit;
        return t;
    endfunction

    assign region = region_e'(bus_req_i.adr[13:12]);
    assign mapped = (bus_req_i.adr[31:14] == MAP_BASE_HI);

    assign sram_req_o = route(bus_req_i, mapped && (region == REG_SRAM));
    assign gpio_req_o = route(bus_req_i, mapped && (region == REG_GPIO));
    assign la_req_o   = route(bus_req_i, mapped && (region == REG_LA));
    assign team_req_o = route(bus_req_i, mapped && (region == REG_TEAM));

    always_comb begin
        bus_rsp_o = '0;
        if (!mapped) begin
            bus_rsp_o.ack = unm_ack_q;  // Data stays zero
        end else begin
            case (region)
                REG_SRAM: bus_rsp_o = sram_rsp_i;
                REG_GPIO: bus_rsp_o = gpio_rsp_i;
                REG_LA:   bus_rsp_o = la_rsp_i;
                REG_TEAM: bus_rsp_o = team_rsp_i;
            endcase
        end
    end

    // Keeps the bus moving when nothing answers
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            unm_ack_q <= 1'b0;
        end else begin
            unm_ack_q <= bus_req_i.cyc & bus_req_i.stb & ~mapped & ~unm_ack_q;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sram_wb.sv ====
/* Word SRAM on Wishbone with byte-lane writes and registered read data
   and acknowledge */
`timescale 1ns/1ps
`default_nettype none

module sram_wb #(
    parameter int SRAM_WORDS = 256
) (
    input  logic            wb_clk_i,
    input  logic            reset_i,
    input  wb_pkg::wb_req_t req_i,
    output wb_pkg::wb_rsp_t rsp_o
);
    import wb_pkg::*;

    localparam int IDX_W = $clog2(SRAM_WORDS);

    logic [WB_DW-1:0] mem [SRAM_WORDS];
    logic [WB_DW-1:0] rdat_q;
    logic [IDX_W-1:0] idx;
    logic             ack_q;
    logic             access;

    assign idx    = req_i.adr[2 +: IDX_W];     // Word address
    assign access = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Array and read data carry no reset
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            if (req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.sel[b]) mem[idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
                end
            end else begin
                rdat_q <= mem[idx];
            end
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdat_q;

endmodule

`default_nettype wire

// ==== verilog/gpio_control.sv ====
/* Pad source select: a Wishbone register picks which source drives
   the pad outputs and output enables */
`timescale 1ns/1ps
`default_nettype none

module gpio_control #(
    parameter int NUM_SOURCES = 2
) (
    input  logic                      wb_clk_i,
    input  logic                      reset_i,
    input  wb_pkg::wb_req_t           req_i,
    output wb_pkg::wb_rsp_t           rsp_o,
    input  logic [38*NUM_SOURCES-1:0] src_out_i,
    input  logic [38*NUM_SOURCES-1:0] src_oeb_i,
    output logic [37:0]               gpio_out_o,
    output logic [37:0]               gpio_oeb_o
);
    import soc_map_pkg::*;

    logic [31:0] sel_q;
    logic [31:0] src_idx;
    logic        ack_q;
    logic        reg_hit;
    logic        wr_en;

    assign reg_hit = (req_i.adr[11:2] == '0);  // Single register at offset 0
    assign wr_en   = req_i.cyc & req_i.stb & req_i.we & ~ack_q & reg_hit;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
            sel_q <= SRC_NONE;
        end else begin
            ack_q <= req_i.cyc & req_i.stb & ~ack_q;
            if (wr_en) begin
                sel_q <= req_i.dat;
            end
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = reg_hit ? sel_q : '0;

    // Out of range select falls back to the default source
    assign src_idx = (sel_q < NUM_SOURCES) ? sel_q : SRC_NONE;

    assign gpio_out_o = src_out_i[src_idx*38 +: 38];
    assign gpio_oeb_o = src_oeb_i[src_idx*38 +: 38];

endmodule

`default_nettype wire

// ==== verilog/la_control.sv ====
/* LA source select: a Wishbone register picks which source drives
   the 128 logic-analyzer outputs */
`timescale 1ns/1ps
`default_nettype none

module la_control #(
    parameter int NUM_SOURCES = 2
) (
    input  logic                       wb_clk_i,
    input  logic                       reset_i,
    input  wb_pkg::wb_req_t            req_i,
    output wb_pkg::wb_rsp_t            rsp_o,
    input  logic [128*NUM_SOURCES-1:0] src_la_i,
    output logic [127:0]               la_data_o
);
    import soc_map_pkg::*;

    logic [31:0] sel_q;
    logic [31:0] src_idx;
    logic        ack_q;
    logic        reg_hit;
    logic        wr_en;

    assign reg_hit = (req_i.adr[11:2] == '0);
    assign wr_en   = req_i.cyc & req_i.stb & req_i.we & ~ack_q & reg_hit;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
            sel_q <= SRC_NONE;
        end else begin
            ack_q <= req_i.cyc & req_i.stb & ~ack_q;
            if (wr_en) sel_q <= req_i.dat;
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = reg_hit ? sel_q : '0;

    assign src_idx   = (sel_q < NUM_SOURCES) ? sel_q : SRC_NONE;  // Fallback
    assign la_data_o = src_la_i[src_idx*128 +: 128];

endmodule

`default_nettype wire

// ==== verilog/team_copy_engine.sv ====
/* Team project: register slave plus a bus manager that copies LEN words
   from SRC to DST, with status on the pads and LA */
`timescale 1ns/1ps
`default_nettype none

module team_copy_engine (
    input  logic            wb_clk_i,
    input  logic            reset_i,
    input  wb_pkg::wb_req_t slv_req_i,
    output wb_pkg::wb_rsp_t slv_rsp_o,
    output wb_pkg::wb_req_t mst_req_o,
    input  wb_pkg::wb_rsp_t mst_rsp_i,
    output logic [37:0]     gpio_out_o,
    output logic [37:0]     gpio_oeb_o,
    output logic [127:0]    la_data_o
);
    import wb_pkg::*;
    import soc_map_pkg::*;

    copy_state_e      state_q;
    logic [WB_DW-1:0] src_q, dst_q, len_q;
    logic [WB_DW-1:0] word_q;           // Word in flight
    logic [WB_DW-1:0] rd_dat;
    logic [15:0]      count_q, count_nxt;
    logic [1:0]       offset;
    logic             in_range, slv_wr, slv_ack_q, req_q, busy, start;

    assign offset    = slv_req_i.adr[3:2];
    assign in_range  = (slv_req_i.adr[11:4] == '0);
    assign slv_wr    = slv_req_i.cyc & slv_req_i.stb & slv_req_i.we & ~slv_ack_q & in_range;
    assign busy      = (state_q != CP_IDLE);
    assign count_nxt = count_q + 16'd1;
    assign start     = slv_wr && (offset == COPY_CTRL) && slv_req_i.dat[0] && (len_q != '0);

    always_comb begin
        rd_dat = '0;
        if (in_range) begin
            case (offset)
                COPY_SRC:  rd_dat = src_q;
                COPY_DST:  rd_dat = dst_q;
                COPY_LEN:  rd_dat = len_q;
                COPY_CTRL: rd_dat = {count_q, 15'd0, busy};
            endcase
        end
    end

    assign slv_rsp_o.ack = slv_ack_q;
    assign slv_rsp_o.dat = rd_dat;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            slv_ack_q <= 1'b0;
            src_q     <= '0;
            dst_q     <= '0;
            len_q     <= '0;
        end else begin
            slv_ack_q <= slv_req_i.cyc & slv_req_i.stb & ~slv_ack_q;
            if (slv_wr && offset == COPY_SRC) src_q <= slv_req_i.dat;
            if (slv_wr && offset == COPY_DST) dst_q <= slv_req_i.dat;
            if (slv_wr && offset == COPY_LEN) len_q <= slv_req_i.dat;
        end
    end

    // req_q drops for one cycle after every ack
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q <= CP_IDLE;
            req_q   <= 1'b0;
            count_q <= '0;
        end else begin
            case (state_q)
                CP_IDLE: begin
                    if (start) begin
                        state_q <= CP_READ;
                        req_q   <= 1'b1;
                        count_q <= '0;
                    end
                end
                CP_READ: begin
                    if (!req_q) begin
                        req_q <= 1'b1;
                    end else if (mst_rsp_i.ack) begin
                        req_q   <= 1'b0;
                        state_q <= CP_WRITE;
                    end
                end
                CP_WRITE: begin
                    if (!req_q) begin
                        req_q <= 1'b1;
                    end else if (mst_rsp_i.ack) begin
                        req_q   <= 1'b0;
                        count_q <= count_nxt;
                        state_q <= ({16'd0, count_nxt} == len_q) ? CP_IDLE : CP_READ;
                    end
                end
                default: state_q <= CP_IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state_q == CP_READ && req_q && mst_rsp_i.ack) word_q <= mst_rsp_i.dat;
    end

    always_comb begin
        mst_req_o.cyc = req_q;
        mst_req_o.stb = req_q;
        mst_req_o.we  = (state_q == CP_WRITE);
        mst_req_o.sel = 4'hf;                       // Full words only
        mst_req_o.adr = ((state_q == CP_WRITE) ? dst_q : src_q) + {14'd0, count_q, 2'b00};
        mst_req_o.dat = word_q;
    end

    assign gpio_out_o = {22'd0, count_q};
    assign gpio_oeb_o = {22'h3f_ffff, 16'h0000};    // Count bits driven
    assign la_data_o  = {96'd0, count_q, 14'd0, state_q};

endmodule

`default_nettype wire

// ==== verilog/nebula_ii.sv ====
/* User-area top: host and copy-engine managers, arbiter, decoder,
   SRAM, GPIO and LA source selection */
`timescale 1ns/1ps
`default_nettype none

module nebula_ii #(
    parameter int NUM_SOURCES = 2,
    parameter int SRAM_WORDS  = 256
) (
    input  logic            wb_clk_i,
    input  logic            reset_i,
    input  wb_pkg::wb_req_t host_req_i,
    output wb_pkg::wb_rsp_t host_rsp_o,
    output logic [37:0]     gpio_out_o,
    output logic [37:0]     gpio_oeb_o,
    output logic [127:0]    la_data_o
);
    import wb_pkg::*;
    import soc_map_pkg::*;

    wb_req_t cpu_req, bus_req, sram_req, gpio_req, la_req, team_req;
    wb_rsp_t cpu_rsp, bus_rsp, sram_rsp, gpio_rsp, la_rsp, team_rsp;

    logic [37:0]                team_gpio_out;
    logic [37:0]                team_gpio_oeb;
    logic [127:0]               team_la;
    logic [38*NUM_SOURCES-1:0]  src_out;
    logic [38*NUM_SOURCES-1:0]  src_oeb;
    logic [128*NUM_SOURCES-1:0] src_la;

    // Flat source vectors, unused slots keep the pad defaults
    always_comb begin
        src_out = '0;
        src_oeb = '1;                   // Pads as inputs
        src_la  = '0;
        src_out[SRC_TEAM5*38 +: 38]  = team_gpio_out;
        src_oeb[SRC_TEAM5*38 +: 38]  = team_gpio_oeb;
        src_la[SRC_TEAM5*128 +: 128] = team_la;
    end

    wb_arbiter u_arbiter (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .host_req_i (host_req_i),
        .cpu_req_i  (cpu_req),
        .host_rsp_o (host_rsp_o),
        .cpu_rsp_o  (cpu_rsp),
        .bus_req_o  (bus_req),
        .bus_rsp_i  (bus_rsp)
    );

    wb_decoder u_decoder (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .bus_req_i  (bus_req),
        .bus_rsp_o  (bus_rsp),
        .sram_req_o (sram_req),
        .gpio_req_o (gpio_req),
        .la_req_o   (la_req),
        .team_req_o (team_req),
        .sram_rsp_i (sram_rsp),
        .gpio_rsp_i (gpio_rsp),
        .la_rsp_i   (la_rsp),
        .team_rsp_i (team_rsp)
    );

    sram_wb #(.SRAM_WORDS(SRAM_WORDS)) u_sram (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .req_i    (sram_req),
        .rsp_o    (sram_rsp)
    );

    gpio_control #(.NUM_SOURCES(NUM_SOURCES)) u_gpio_control (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .req_i      (gpio_req),
        .rsp_o      (gpio_rsp),
        .src_out_i  (src_out),
        .src_oeb_i  (src_oeb),
        .gpio_out_o (gpio_out_o),
        .gpio_oeb_o (gpio_oeb_o)
    );

    la_control #(.NUM_SOURCES(NUM_SOURCES)) u_la_control (
        .wb_clk_i  (wb_clk_i),
        .reset_i   (reset_i),
        .req_i     (la_req),
        .rsp_o     (la_rsp),
        .src_la_i  (src_la),
        .la_data_o (la_data_o)
    );

    // Team 5 slot
    team_copy_engine u_team (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .slv_req_i  (team_req),
        .slv_rsp_o  (team_rsp),
        .mst_req_o  (cpu_req),
        .mst_rsp_i  (cpu_rsp),
        .gpio_out_o (team_gpio_out),
        .gpio_oeb_o (team_gpio_oeb),
        .la_data_o  (team_la)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
/* Free-running testbench clock */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== test/nebula_ii_assert.sv ====
/* Host handshake, single-cycle ack and reset-state checks, bound into
   the user-area top */
`timescale 1ns/1ps
`default_nettype none

module nebula_ii_assert (
    input logic            wb_clk_i,
    input logic            reset_i,
    input wb_pkg::wb_req_t host_req_i,
    input wb_pkg::wb_rsp_t host_rsp_i,
    input wb_pkg::wb_rsp_t bus_rsp_i,
    input wb_pkg::wb_req_t cpu_req_i,
    input logic [37:0]     gpio_oeb_i
);

    int unsigned fail_count = 0;    // Failed checks so far

    // Host only sees an ack while its own strobe is up
    host_ack_needs_stb: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        host_rsp_i.ack |-> (host_req_i.cyc && host_req_i.stb))
    else begin
        $error("host ack seen without host cyc and stb");
        fail_count++;
    end

    host_ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        host_rsp_i.ack |=> !host_rsp_i.ack)
    else begin
        $error("host ack held for two cycles");
        fail_count++;
    end

    // Any target, either manager
    bus_ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        bus_rsp_i.ack |=> !bus_rsp_i.ack)
    else begin
        $error("bus ack held for two cycles");
        fail_count++;
    end

    // Registers settle after the first reset edge
    reset_state: assert property (@(posedge wb_clk_i)
        (reset_i && $past(reset_i)) |-> (!cpu_req_i.cyc && gpio_oeb_i == '1))
    else begin
        $error("copy engine cyc or pad enables wrong during reset");
        fail_count++;
    end

endmodule

bind nebula_ii nebula_ii_assert u_assert (
    .wb_clk_i   (wb_clk_i),
    .reset_i    (reset_i),
    .host_req_i (host_req_i),
    .host_rsp_i (host_rsp_o),
    .bus_rsp_i  (bus_rsp),
    .cpu_req_i  (cpu_req),
    .gpio_oeb_i (gpio_oeb_o)
);

`default_nettype wire

// ==== test/nebula_ii_tb.sv ====
/* Testbench top: host bus tasks, SRAM and select reference model,
   read-data and output checks, timeout */
`timescale 1ns/1ps
`default_nettype none

module nebula_ii_tb;
    import wb_pkg::*;
    import soc_map_pkg::*;

    localparam int          NUM_SOURCES    = 2;
    localparam int          SRAM_WORDS     = 256;
    localparam int          TIMEOUT_CYCLES = 4000;  // ~170 accesses at ~4 cycles plus copy
    localparam logic [31:0] SEED           = 32'hbfb4_0888;
    localparam logic [31:0] SRAM_BASE      = {MAP_BASE_HI, REG_SRAM, 12'h000};
    localparam logic [31:0] GPIO_BASE      = {MAP_BASE_HI, REG_GPIO, 12'h000};
    localparam logic [31:0] LA_BASE        = {MAP_BASE_HI, REG_LA, 12'h000};

    logic          wb_clk_i;
    logic          reset_i;
    wb_req_t       host_req_i;
    wb_rsp_t       host_rsp_o;
    logic [37:0]   gpio_out_o;
    logic [37:0]   gpio_oeb_o;
    logic [127:0]  la_data_o;

    logic [31:0]   sram_model [SRAM_WORDS];
    logic [31:0]   gpio_sel_m = SRC_NONE;
    logic [31:0]   la_sel_m   = SRC_NONE;
    logic [15:0]   copied     = '0;       // Words copied by the engine
    logic          check_read;
    logic [31:0]   exp_read;
    int            cycles = 0;

    tb_clock #(.PERIOD_NS(100)) u_clock (.clk_o(wb_clk_i));

    nebula_ii #(
        .NUM_SOURCES (NUM_SOURCES),
        .SRAM_WORDS  (SRAM_WORDS)
    ) UUT (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .host_req_i (host_req_i),
        .host_rsp_o (host_rsp_o),
        .gpio_out_o (gpio_out_o),
        .gpio_oeb_o (gpio_oeb_o),
        .la_data_o  (la_data_o)
    );

    // Data of every acknowledged host read
    read_data_check: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        (host_rsp_o.ack && !host_req_i.we && check_read) |-> (host_rsp_o.dat == exp_read))
    else begin
        $display("ERROR at %0t: host_rsp_o.dat = %h, expected %h",
                 $time, $sampled(host_rsp_o.dat), $sampled(exp_read));
        $display(">>> FAIL");
        $fatal(1, "read data mismatch");
    end

    always @(posedge wb_clk_i) begin
        cycles <= cycles + 1;
        if (UUT.u_assert.fail_count != 0) begin
            $display("ERROR at %0t: a bus protocol check in the bound checker failed", $time);
            $display(">>> FAIL");
            $fatal(1, "protocol check failed");
        end else if (cycles >= TIMEOUT_CYCLES) begin
            $display("ERROR at %0t: run did not finish within %0d cycles", $time, cycles);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] team_reg(input logic [1:0] offset);
        return {MAP_BASE_HI, REG_TEAM, 8'h00, offset, 2'b00};
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  sel);
        logic [31:0] w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) w[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return w;
    endfunction

    // One host cycle, held until the ack
    task automatic host_access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                               input logic [31:0] wdat, input logic check,
                               input logic [31:0] expected, output logic [31:0] rdat);
        wb_req_t r;
        r     = '0;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.we  = we;
        r.sel = sel;
        r.adr = adr;
        r.dat = wdat;
        @(posedge wb_clk_i);
        check_read <= check;
        exp_read   <= expected;
        host_req_i <= r;
        @(posedge wb_clk_i);
        while (!host_rsp_o.ack) @(posedge wb_clk_i);
        rdat = host_rsp_o.dat;
        host_req_i <= '0;
    endtask

    task automatic host_write(input logic [31:0] adr, input logic [3:0] sel,
                              input logic [31:0] dat);
        logic [31:0] unused;
        host_access(1'b1, sel, adr, dat, 1'b0, '0, unused);
    endtask

    task automatic host_read(input logic [31:0] adr, input logic check,
                             input logic [31:0] expected, output logic [31:0] dat);
        host_access(1'b0, 4'hf, adr, '0, check, expected, dat);
    endtask

    task automatic sram_write(input int word, input logic [3:0] sel, input logic [31:0] dat);
        sram_model[word] = merge_lanes(sram_model[word], dat, sel);
        host_write(SRAM_BASE + 32'(word) * 4, sel, dat);
    endtask

    task automatic expect_bits(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        assert (actual === expected) else begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    // Pads and LA from the model selects, team source only for select 1
    task automatic check_outputs();
        logic [37:0]  out_exp;
        logic [37:0]  oeb_exp;
        logic [127:0] la_exp;
        out_exp = '0;
        oeb_exp = '1;
        la_exp  = '0;
        if (gpio_sel_m == SRC_TEAM5) begin
            out_exp = {22'd0, copied};
            oeb_exp = {22'h3f_ffff, 16'h0000};
        end
        if (la_sel_m == SRC_TEAM5) la_exp = {96'd0, copied, 14'd0, CP_IDLE};
        @(negedge wb_clk_i);
        expect_bits("gpio_out_o", gpio_out_o, out_exp);
        expect_bits("gpio_oeb_o", gpio_oeb_o, oeb_exp);
        expect_bits("la_data_o", la_data_o, la_exp);
    endtask

    task automatic apply_select(input logic la_side, input logic [31:0] value);
        logic [31:0] rd;
        if (la_side) la_sel_m = value;
        else gpio_sel_m = value;
        host_write(la_side ? LA_BASE : GPIO_BASE, 4'hf, value);
        host_read(la_side ? LA_BASE : GPIO_BASE, 1'b1, value, rd);
        check_outputs();
    endtask

    initial begin
        logic [31:0] rd;
        reset_i    = 1'b1;
        host_req_i = '0;
        check_read = 1'b0;
        exp_read   = '0;
        void'($urandom(SEED));
        repeat (16) @(posedge wb_clk_i);
        reset_i <= 1'b0;
        check_outputs();

        // SRAM: fill, then partial lane writes, then read back
        for (int i = 0; i < 32; i++) sram_write(i, 4'hf, $urandom);
        for (int i = 0; i < 24; i++) sram_write($urandom % 32, 4'($urandom), $urandom);
        for (int i = 0; i < 32; i++) host_read(SRAM_BASE + 32'(i) * 4, 1'b1, sram_model[i], rd);

        host_read(32'h2000_0040, 1'b1, '0, rd);     // Outside the user area
        host_read(GPIO_BASE + 32'h4, 1'b1, '0, rd);
        host_read(team_reg(COPY_CTRL) + 32'h10, 1'b1, '0, rd);

        // Copy words 0..7 to 64..71, polling shares the bus with the engine
        host_write(team_reg(COPY_SRC), 4'hf, SRAM_BASE);
        host_write(team_reg(COPY_DST), 4'hf, SRAM_BASE + 32'h100);
        host_write(team_reg(COPY_LEN), 4'hf, 32'd8);
        host_write(team_reg(COPY_CTRL), 4'hf, 32'd1);
        do begin
            host_read(team_reg(COPY_CTRL), 1'b0, '0, rd);
        end while (rd[0]);
        host_read(team_reg(COPY_CTRL), 1'b1, {16'd8, 16'd0}, rd);
        copied = 16'd8;
        for (int k = 0; k < 8; k++) begin
            sram_model[64 + k] = sram_model[k];
            host_read(SRAM_BASE + 32'(64 + k) * 4, 1'b1, sram_model[64 + k], rd);
        end

        apply_select(1'b0, SRC_TEAM5);
        apply_select(1'b0, SRC_NONE);
        apply_select(1'b0, 32'd3);
        for (int i = 0; i < 3; i++) apply_select(1'b0, $urandom % 4);
        apply_select(1'b0, SRC_NONE);
        apply_select(1'b1, SRC_TEAM5);
        apply_select(1'b1, 32'd3);
        for (int i = 0; i < 3; i++) apply_select(1'b1, $urandom % 4);
        apply_select(1'b1, SRC_NONE);

        repeat (2) @(posedge wb_clk_i);
        if (UUT.u_assert.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("ERROR at %0t: a bus protocol check in the bound checker failed", $time);
            $display(">>> FAIL");
            $fatal(1, "protocol check failed");
        end
    end

endmodule

`default_nettype wire

// ==== nebula_ii.f ====
verilog/wb_pkg.sv
verilog/soc_map_pkg.sv
verilog/wb_arbiter.sv
verilog/wb_decoder.sv
verilog/sram_wb.sv
verilog/gpio_control.sv
verilog/la_control.sv
verilog/team_copy_engine.sv
verilog/nebula_ii.sv
test/tb_clock.sv
test/nebula_ii_assert.sv
test/nebula_ii_tb.sv
